/* zx_mem_pkg.sv */
package zx_mem_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] mem_data_t;

	// 16K page number
	typedef logic [4:0] page_t;

	// page on top of a 14-bit offset within the page
	typedef logic [18:0] phys_addr_t;

	typedef logic [7:0] port7ffd_t;

	// 7FFD bit fields
	localparam int P7FFD_RAM_MSB = 2;
	localparam int P7FFD_SCREEN = 3;
	localparam int P7FFD_ROM = 4;
	localparam int P7FFD_LOCK = 5;

	localparam page_t PAGE_SCREEN0 = 5'd5;
	localparam page_t PAGE_SCREEN1 = 5'd7;

	// fixed pages behind 4000 and 8000
	localparam page_t PAGE_WIN1 = 5'd5;
	localparam page_t PAGE_WIN2 = 5'd2;

endpackage

/* zx_video_pkg.sv */
package zx_video_pkg;

	// who owns the current memory slot
	typedef enum logic [1:0]
	{
		ARB_IDLE,
		ARB_VIDEO,
		ARB_CPU,
		ARB_DONE
	} arb_state_t;

	// byte position inside one fetched screen line
	typedef logic [7:0] line_byte_t;

endpackage

/* slot_timer.sv */
`timescale 1ns/1ps

module slot_timer #(
	parameter int SLOT_LEN = 4,
	parameter int LINE_SLOTS = 64
)(
	input logic fclk,
	input logic rst,
	output logic slot_beg,
	output logic slot_end,
	output logic line_start
);

	localparam int CW = $clog2(SLOT_LEN);
	localparam int SW = $clog2(LINE_SLOTS);

	logic [CW-1:0] cyc_cnt;
	logic [CW-1:0] cyc_next;
	logic [SW-1:0] slot_cnt;
	logic [SW-1:0] slot_next;

	assign cyc_next = (cyc_cnt == CW'(SLOT_LEN - 1)) ? '0 : cyc_cnt + 1'b1;

	always_comb
	begin
		slot_next = slot_cnt;
		if (cyc_cnt == CW'(SLOT_LEN - 1))
		begin
			if (slot_cnt == SW'(LINE_SLOTS - 1))
				slot_next = '0;
			else
				slot_next = slot_cnt + 1'b1;
		end
	end

	// reset parks the counters on the last cycle of the line, so the
	// first cycle after release is cycle 0 of slot 0
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			cyc_cnt <= CW'(SLOT_LEN - 1);
			slot_cnt <= SW'(LINE_SLOTS - 1);
			slot_beg <= 1'b0;
			slot_end <= 1'b0;
			line_start <= 1'b0;
		end
		else
		begin
			cyc_cnt <= cyc_next;
			slot_cnt <= slot_next;
			slot_beg <= (cyc_next == '0);
			slot_end <= (cyc_next == CW'(SLOT_LEN - 1));
			line_start <= (cyc_next == '0) && (slot_next == '0);
		end
	end

endmodule

/* page_mapper.sv */
`timescale 1ns/1ps

module page_mapper #(
	parameter zx_mem_pkg::page_t ROM_BASE_PAGE = 5'd30
)(
	input logic fclk,
	input logic rst,
	input logic io_wr,
	input zx_mem_pkg::cpu_addr_t io_addr,
	input zx_mem_pkg::mem_data_t io_data,
	input zx_mem_pkg::cpu_addr_t cpu_addr,
	input logic cpu_rnw,
	output zx_mem_pkg::phys_addr_t cpu_phys,
	output logic cpu_rom_wr,
	output logic screen_sel
);

	import zx_mem_pkg::*;

	port7ffd_t port7ffd;
	page_t win_page;
	logic port_hit;

	// partial decode, A15 and A1 low
	assign port_hit = io_wr && !io_addr[15] && !io_addr[1];

	// once locked, only reset opens the port again
	always_ff @(posedge fclk)
	begin
		if (rst)
			port7ffd <= '0;
		else if (port_hit && !port7ffd[P7FFD_LOCK])
			port7ffd <= io_data;
	end

	always_comb
	begin
		case (cpu_addr[15:14])
			2'd0:
				win_page = ROM_BASE_PAGE + page_t'(port7ffd[P7FFD_ROM]);
			2'd1:
				win_page = PAGE_WIN1;
			2'd2:
				win_page = PAGE_WIN2;
			default:
				win_page = {2'b00, port7ffd[P7FFD_RAM_MSB:0]};
		endcase
	end

	assign cpu_phys = {win_page, cpu_addr[13:0]};

	// rom window is read only, the arbiter drops the memory write
	assign cpu_rom_wr = !cpu_rnw && (cpu_addr[15:14] == 2'd0);

	assign screen_sel = port7ffd[P7FFD_SCREEN];

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input logic fclk,
	input logic rst,
	input logic slot_beg,
	input logic slot_end,
	input logic vid_req,
	input zx_mem_pkg::phys_addr_t vid_addr,
	input logic cpu_req,
	input logic cpu_rnw,
	input zx_mem_pkg::phys_addr_t cpu_phys,
	input zx_mem_pkg::mem_data_t cpu_wrdata,
	input logic cpu_rom_wr,
	input zx_mem_pkg::mem_data_t mem_rddata,
	output logic vid_ack,
	output logic cpu_strobe,
	output zx_mem_pkg::mem_data_t cpu_rddata,
	output logic mem_req,
	output zx_mem_pkg::phys_addr_t mem_addr,
	output logic mem_rnw,
	output zx_mem_pkg::mem_data_t mem_wrdata
);

	import zx_video_pkg::*;

	arb_state_t state;
	arb_state_t state_next;
	logic grant_vid;
	logic grant_cpu;

	// done overlaps the next slot_beg; video may still take that slot
	assign grant_vid = slot_beg && vid_req && (state == ARB_IDLE || state == ARB_DONE);

	// the finishing cpu request is still up during done
	assign grant_cpu = slot_beg && (state == ARB_IDLE) && !vid_req && cpu_req;

	always_comb
	begin
		state_next = state;
		case (state)
			ARB_IDLE:
			begin
				if (grant_vid)
					state_next = ARB_VIDEO;
				else if (grant_cpu)
					state_next = ARB_CPU;
			end
			ARB_VIDEO:
			begin
				if (slot_end)
					state_next = ARB_IDLE;
			end
			ARB_CPU:
			begin
				if (slot_end)
					state_next = ARB_DONE;
			end
			default:
			begin
				state_next = grant_vid ? ARB_VIDEO : ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge fclk)
	begin
		if (state == ARB_CPU && slot_end)
			cpu_rddata <= mem_rddata;
	end

	// one-cycle request on the granting slot_beg
	assign mem_req = grant_vid || (grant_cpu && !cpu_rom_wr);
	assign mem_addr = grant_vid ? vid_addr : cpu_phys;
	assign mem_rnw = grant_vid || cpu_rnw;
	assign mem_wrdata = cpu_wrdata;

	assign vid_ack = (state == ARB_VIDEO) && slot_end;
	assign cpu_strobe = (state == ARB_DONE);

endmodule

/* video_fetch.sv */
`timescale 1ns/1ps

module video_fetch #(
	parameter int VIDEO_BYTES = 32
)(
	input logic fclk,
	input logic rst,
	input logic line_start,
	input logic vid_ack,
	input logic screen_sel,
	input zx_mem_pkg::mem_data_t mem_rddata,
	output logic vid_req,
	output zx_mem_pkg::phys_addr_t vid_addr,
	output zx_mem_pkg::mem_data_t video_data,
	output logic video_strobe
);

	import zx_mem_pkg::*;
	import zx_video_pkg::*;

	logic active;
	logic scr_q;
	logic cur_scr;
	line_byte_t byte_idx;
	line_byte_t cur_byte;
	page_t scr_page;

	// line index times VIDEO_BYTES, wraps inside the page
	logic [13:0] line_base;
	logic [13:0] offset;

	// byte 0 must go out in slot 0, so line_start requests directly
	assign cur_scr = line_start ? screen_sel : scr_q;
	assign cur_byte = line_start ? '0 : byte_idx;
	assign scr_page = cur_scr ? PAGE_SCREEN1 : PAGE_SCREEN0;
	assign offset = line_base + 14'(cur_byte);

	assign vid_req = line_start || active;
	assign vid_addr = {scr_page, offset};

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			scr_q <= 1'b0;
			byte_idx <= '0;
			line_base <= '0;
			video_strobe <= 1'b0;
		end
		else
		begin
			video_strobe <= vid_ack;
			if (line_start)
			begin
				active <= 1'b1;
				scr_q <= screen_sel;
				byte_idx <= '0;
			end
			else if (vid_ack && active)
			begin
				if (byte_idx == line_byte_t'(VIDEO_BYTES - 1))
				begin
					active <= 1'b0;
					byte_idx <= '0;
					line_base <= line_base + 14'(VIDEO_BYTES);
				end
				else
					byte_idx <= byte_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (vid_ack)
			video_data <= mem_rddata;
	end

endmodule

/* zx_mem_top.sv */
`timescale 1ns/1ps

module zx_mem_top #(
	parameter int SLOT_LEN = 4,
	parameter int LINE_SLOTS = 64,
	parameter int VIDEO_BYTES = 32,
	parameter zx_mem_pkg::page_t ROM_BASE_PAGE = 5'd30
)(
	input logic fclk,
	input logic rst,
	input logic cpu_req,
	input logic cpu_rnw,
	input zx_mem_pkg::cpu_addr_t cpu_addr,
	input zx_mem_pkg::mem_data_t cpu_wrdata,
	input logic io_wr,
	input zx_mem_pkg::cpu_addr_t io_addr,
	input zx_mem_pkg::mem_data_t io_data,
	input zx_mem_pkg::mem_data_t mem_rddata,
	output zx_mem_pkg::mem_data_t cpu_rddata,
	output logic cpu_strobe,
	output logic mem_req,
	output zx_mem_pkg::phys_addr_t mem_addr,
	output logic mem_rnw,
	output zx_mem_pkg::mem_data_t mem_wrdata,
	output zx_mem_pkg::mem_data_t video_data,
	output logic video_strobe,
	output logic line_start
);

	import zx_mem_pkg::*;

	logic slot_beg;
	logic slot_end;
	phys_addr_t cpu_phys;
	logic cpu_rom_wr;
	logic screen_sel;
	logic vid_req;
	phys_addr_t vid_addr;
	logic vid_ack;

	slot_timer #(
		.SLOT_LEN(SLOT_LEN),
		.LINE_SLOTS(LINE_SLOTS)
	) slots (
		.fclk(fclk),
		.rst(rst),
		.slot_beg(slot_beg),
		.slot_end(slot_end),
		.line_start(line_start)
	);

	page_mapper #(
		.ROM_BASE_PAGE(ROM_BASE_PAGE)
	) mapper (
		.fclk(fclk),
		.rst(rst),
		.io_wr(io_wr),
		.io_addr(io_addr),
		.io_data(io_data),
		.cpu_addr(cpu_addr),
		.cpu_rnw(cpu_rnw),
		.cpu_phys(cpu_phys),
		.cpu_rom_wr(cpu_rom_wr),
		.screen_sel(screen_sel)
	);

	mem_arbiter arb (
		.fclk(fclk),
		.rst(rst),
		.slot_beg(slot_beg),
		.slot_end(slot_end),
		.vid_req(vid_req),
		.vid_addr(vid_addr),
		.cpu_req(cpu_req),
		.cpu_rnw(cpu_rnw),
		.cpu_phys(cpu_phys),
		.cpu_wrdata(cpu_wrdata),
		.cpu_rom_wr(cpu_rom_wr),
		.mem_rddata(mem_rddata),
		.vid_ack(vid_ack),
		.cpu_strobe(cpu_strobe),
		.cpu_rddata(cpu_rddata),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_rnw(mem_rnw),
		.mem_wrdata(mem_wrdata)
	);

	video_fetch #(
		.VIDEO_BYTES(VIDEO_BYTES)
	) fetcher (
		.fclk(fclk),
		.rst(rst),
		.line_start(line_start),
		.vid_ack(vid_ack),
		.screen_sel(screen_sel),
		.mem_rddata(mem_rddata),
		.vid_req(vid_req),
		.vid_addr(vid_addr),
		.video_data(video_data),
		.video_strobe(video_strobe)
	);

endmodule

/* zx_mem_assert.sv */
`timescale 1ns/1ps

module zx_mem_assert #(
	parameter int VIDEO_BYTES = 32
)(
	input logic fclk,
	input logic rst,
	input logic slot_beg,
	input logic mem_req,
	input logic cpu_req,
	input logic cpu_strobe,
	input logic video_strobe,
	input logic line_start
);

	int strobe_cnt;
	logic line_seen;
	int fail_cnt = 0;

	// video strobes since the last line start
	always @(posedge fclk)
	begin
		if (rst)
		begin
			strobe_cnt <= 0;
			line_seen <= 1'b0;
		end
		else if (line_start)
		begin
			strobe_cnt <= 0;
			line_seen <= 1'b1;
		end
		else if (video_strobe)
			strobe_cnt <= strobe_cnt + 1;
	end

	mem_req_on_slot: assert property (@(posedge fclk) disable iff (rst)
		mem_req |-> slot_beg)
		else
		begin
			$error("mem_req raised outside a slot begin cycle");
			fail_cnt++;
		end

	mem_req_one_cycle: assert property (@(posedge fclk) disable iff (rst)
		mem_req |=> !mem_req)
		else
		begin
			$error("mem_req held longer than one cycle");
			fail_cnt++;
		end

	strobe_needs_req: assert property (@(posedge fclk) disable iff (rst)
		cpu_strobe |-> cpu_req)
		else
		begin
			$error("cpu_strobe without a pending cpu_req");
			fail_cnt++;
		end

	bytes_per_line: assert property (@(posedge fclk) disable iff (rst)
		(line_start && line_seen) |-> (strobe_cnt == VIDEO_BYTES))
		else
		begin
			$error("wrong number of video strobes in the previous line");
			fail_cnt++;
		end

endmodule

/* tb_zx_mem.sv */
`timescale 1ns/1ps

module tb_zx_mem;

	import zx_mem_pkg::*;

	localparam int SLOT_LEN = 4;
	localparam int LINE_SLOTS = 16;
	localparam int VIDEO_BYTES = 8;
	localparam page_t ROM_BASE_PAGE = 5'd30;
	localparam int WAIT_LIMIT = 4 * SLOT_LEN * LINE_SLOTS;

	logic fclk;
	logic rst;
	logic cpu_req;
	logic cpu_rnw;
	cpu_addr_t cpu_addr;
	mem_data_t cpu_wrdata;
	logic io_wr;
	cpu_addr_t io_addr;
	mem_data_t io_data;
	mem_data_t mem_rddata = '0;
	mem_data_t cpu_rddata;
	logic cpu_strobe;
	logic mem_req;
	phys_addr_t mem_addr;
	logic mem_rnw;
	mem_data_t mem_wrdata;
	mem_data_t video_data;
	logic video_strobe;
	logic line_start;

	mem_data_t mem [0:524287];
	int line_cnt;
	int errors;
	int failed_tests;
	integer seed;

	zx_mem_top #(
		.SLOT_LEN(SLOT_LEN),
		.LINE_SLOTS(LINE_SLOTS),
		.VIDEO_BYTES(VIDEO_BYTES),
		.ROM_BASE_PAGE(ROM_BASE_PAGE)
	) UUT (
		.fclk(fclk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_rnw(cpu_rnw),
		.cpu_addr(cpu_addr),
		.cpu_wrdata(cpu_wrdata),
		.io_wr(io_wr),
		.io_addr(io_addr),
		.io_data(io_data),
		.mem_rddata(mem_rddata),
		.cpu_rddata(cpu_rddata),
		.cpu_strobe(cpu_strobe),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_rnw(mem_rnw),
		.mem_wrdata(mem_wrdata),
		.video_data(video_data),
		.video_strobe(video_strobe),
		.line_start(line_start)
	);

	bind zx_mem_top zx_mem_assert #(
		.VIDEO_BYTES(VIDEO_BYTES)
	) protocol_check (
		.fclk(fclk),
		.rst(rst),
		.slot_beg(slot_beg),
		.mem_req(mem_req),
		.cpu_req(cpu_req),
		.cpu_strobe(cpu_strobe),
		.video_strobe(video_strobe),
		.line_start(line_start)
	);

	always #10 fclk = ~fclk;

	// byte-wide memory, read data registered and then held
	always @(posedge fclk)
	begin
		if (mem_req && !mem_rnw)
			mem[mem_addr] = mem_wrdata;
		if (mem_req && mem_rnw)
			mem_rddata <= mem[mem_addr];
	end

	// index of the current line since reset
	always @(posedge fclk)
	begin
		if (rst)
			line_cnt <= 0;
		else if (line_start)
			line_cnt <= line_cnt + 1;
	end

	// page bits land on their own byte lanes
	function automatic mem_data_t fill_byte(input phys_addr_t a);
		fill_byte = a[7:0] ^ {a[18:14], a[13:11]} ^ {a[10:8], 5'b0};
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] expv,
		input logic [31:0] got);
		$display("FAIL %0t %s expected %0h got %0h", $time, sig, expv, got);
		errors++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d errors", name, errors - errs_before);
			failed_tests++;
		end
	endtask

	task automatic apply_reset();
		@(posedge fclk);
		rst <= 1'b1;
		repeat (8) @(posedge fclk);
		rst <= 1'b0;
	endtask

	task automatic port_write(input cpu_addr_t addr, input mem_data_t data);
		@(posedge fclk);
		io_wr <= 1'b1;
		io_addr <= addr;
		io_data <= data;
		@(posedge fclk);
		io_wr <= 1'b0;
	endtask

	// cycles counts from the cycle after the call's first edge
	task automatic cpu_access(input logic rnw, input cpu_addr_t addr, input mem_data_t wdata,
		output mem_data_t rdata, output int cycles);
		@(posedge fclk);
		cpu_req <= 1'b1;
		cpu_rnw <= rnw;
		cpu_addr <= addr;
		cpu_wrdata <= wdata;
		cycles = 0;
		do
		begin
			@(negedge fclk);
			cycles++;
		end
		while (!cpu_strobe && cycles < WAIT_LIMIT);
		rdata = cpu_rddata;
		if (!cpu_strobe)
		begin
			$display("timeout: no cpu_strobe for address %h at %0t", addr, $time);
			errors++;
		end
		@(posedge fclk);
		cpu_req <= 1'b0;
	endtask

	task automatic wait_line_start(output logic seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT)
		begin
			@(negedge fclk);
			n++;
			seen = line_start;
		end
		if (!seen)
		begin
			$display("timeout: no line_start at %0t", $time);
			errors++;
		end
	endtask

	task automatic read_upper_window(input page_t pg);
		cpu_addr_t a;
		mem_data_t rd;
		int cyc;
		a = 16'hc000 | 16'h0a5c;
		cpu_access(1'b1, a, 8'h00, rd, cyc);
		if (rd !== mem[{pg, a[13:0]}])
			report_mismatch("cpu_rddata", mem[{pg, a[13:0]}], rd);
	endtask

	// one line of screen bytes, byte k strobes k*SLOT_LEN+SLOT_LEN after line_start
	task automatic check_line(input page_t pg);
		logic seen;
		int line;
		int cyc;
		int k;
		phys_addr_t pa;
		wait_line_start(seen);
		line = line_cnt;
		cyc = 0;
		for (k = 0; k < VIDEO_BYTES && seen; k++)
		begin
			do
			begin
				@(negedge fclk);
				cyc++;
			end
			while (!video_strobe && cyc < WAIT_LIMIT);
			if (!video_strobe)
			begin
				$display("timeout: video byte %0d never strobed at %0t", k, $time);
				errors++;
				seen = 1'b0;
			end
			else
			begin
				pa = {pg, 14'((line * VIDEO_BYTES + k) % 16384)};
				if (cyc != k * SLOT_LEN + SLOT_LEN)
					report_mismatch("video_strobe cycle", k * SLOT_LEN + SLOT_LEN, cyc);
				if (video_data !== mem[pa])
					report_mismatch("video_data", mem[pa], video_data);
			end
		end
	endtask

	task automatic test_reset_state();
		int e0;
		int cyc;
		cpu_addr_t a;
		mem_data_t d;
		mem_data_t rd;
		e0 = errors;
		apply_reset();
		@(negedge fclk);
		if (mem_req !== 1'b0)
			report_mismatch("mem_req", 0, mem_req);
		if (cpu_strobe !== 1'b0)
			report_mismatch("cpu_strobe", 0, cpu_strobe);
		if (video_strobe !== 1'b0)
			report_mismatch("video_strobe", 0, video_strobe);
		a = {2'b11, 14'($random(seed))};
		d = mem_data_t'($random(seed));
		cpu_access(1'b0, a, d, rd, cyc);
		if (mem[{5'd0, a[13:0]}] !== d)
			report_mismatch("mem page 0", d, mem[{5'd0, a[13:0]}]);
		end_test("reset state", e0);
	endtask

	task automatic test_windows();
		int e0;
		int cyc;
		int w;
		cpu_addr_t a;
		mem_data_t d;
		mem_data_t rd;
		page_t pg;
		e0 = errors;
		for (w = 1; w < 4; w++)
		begin
			a = {w[1:0], 14'($random(seed))};
			d = mem_data_t'($random(seed));
			pg = (w == 1) ? 5'd5 : (w == 2) ? 5'd2 : 5'd0;
			cpu_access(1'b0, a, d, rd, cyc);
			if (mem[{pg, a[13:0]}] !== d)
				report_mismatch("mem window write", d, mem[{pg, a[13:0]}]);
			cpu_access(1'b1, a, 8'h00, rd, cyc);
			if (rd !== d)
				report_mismatch("cpu_rddata", d, rd);
		end
		end_test("window mapping", e0);
	endtask

	task automatic test_paging();
		int e0;
		int cyc;
		cpu_addr_t a;
		mem_data_t rd;
		mem_data_t old;
		page_t rom_pg;
		e0 = errors;
		rom_pg = ROM_BASE_PAGE + 5'd1;
		// ram page 3, rom 1
		port_write(16'h7ffd, 8'h13);
		read_upper_window(5'd3);
		a = 16'h1234;
		cpu_access(1'b1, a, 8'h00, rd, cyc);
		if (rd !== mem[{rom_pg, a[13:0]}])
			report_mismatch("cpu_rddata rom", mem[{rom_pg, a[13:0]}], rd);
		old = mem[{rom_pg, a[13:0]}];
		cpu_access(1'b0, a, ~old, rd, cyc);
		if (mem[{rom_pg, a[13:0]}] !== old)
			report_mismatch("mem rom", old, mem[{rom_pg, a[13:0]}]);
		end_test("paging and rom", e0);
	endtask

	task automatic test_lock();
		int e0;
		e0 = errors;
		// A1 high, not the paging port
		port_write(16'h7fff, 8'h04);
		read_upper_window(5'd3);
		port_write(16'h7ffd, 8'h26);
		read_upper_window(5'd6);
		port_write(16'h7ffd, 8'h01);
		read_upper_window(5'd6);
		apply_reset();
		read_upper_window(5'd0);
		end_test("port lock", e0);
	endtask

	task automatic test_video();
		int e0;
		e0 = errors;
		check_line(5'd5);
		port_write(16'h7ffd, 8'h08);
		check_line(5'd7);
		end_test("video fetch", e0);
	endtask

	task automatic test_contention();
		int e0;
		int cyc;
		logic seen;
		cpu_addr_t a;
		mem_data_t rd;
		e0 = errors;
		wait_line_start(seen);
		a = {2'b10, 14'($random(seed))};
		cpu_access(1'b1, a, 8'h00, rd, cyc);
		// first free slot is the one after the video bytes
		if (cyc != VIDEO_BYTES * SLOT_LEN + SLOT_LEN)
			report_mismatch("cpu_strobe cycle", VIDEO_BYTES * SLOT_LEN + SLOT_LEN, cyc);
		if (rd !== mem[{5'd2, a[13:0]}])
			report_mismatch("cpu_rddata", mem[{5'd2, a[13:0]}], rd);
		end_test("contention", e0);
	endtask

	initial
	begin
		int i;
		fclk = 1'b0;
		rst = 1'b1;
		cpu_req = 1'b0;
		cpu_rnw = 1'b1;
		cpu_addr = '0;
		cpu_wrdata = '0;
		io_wr = 1'b0;
		io_addr = '0;
		io_data = '0;
		errors = 0;
		failed_tests = 0;
		seed = 32'h4a27;
		for (i = 0; i < 524288; i++)
			mem[i] = fill_byte(phys_addr_t'(i));
		test_reset_state();
		test_windows();
		test_paging();
		test_lock();
		test_video();
		test_contention();
		$display("tests 6, failed tests %0d, errors %0d, assertion failures %0d",
			failed_tests, errors, UUT.protocol_check.fail_cnt);
		if (errors == 0 && UUT.protocol_check.fail_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#1000000;
		$display("run time limit reached before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* vlog.f */
zx_mem_pkg.sv
zx_video_pkg.sv
slot_timer.sv
page_mapper.sv
mem_arbiter.sv
video_fetch.sv
zx_mem_top.sv
zx_mem_assert.sv
tb_zx_mem.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_mem -f vlog.f -o sim_zx_mem
./obj_dir/sim_zx_mem 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
